//--- Bender.yml
package:
  name: arcade_ctrl

sources:
  - src/arcade_ctrl_pkg.sv
  - src/opt_if.sv
  - src/opt_regs_decode.sv
  - src/analog_scale.sv
  - src/ctrl_result.sv
  - src/arcade_ctrl_top.sv
  - target: test
    files:
      - sim/tb_arcade_ctrl.sv

//--- files.f
src/arcade_ctrl_pkg.sv
src/opt_if.sv
src/opt_regs_decode.sv
src/analog_scale.sv
src/ctrl_result.sv
src/arcade_ctrl_top.sv
sim/tb_arcade_ctrl.sv

//--- sim/arcade_ctrl_cases.txt
# op a b c d e, all hex | download: cycles settle | button: level | coin: index mask
# write/read: addr data resp | status: sysrst pause dswa dswb | analog: opt p1 p2 out1 out2
status   1        0        ff ff 0
write    0        00000100 0  0  0
status   1        1        ff ff 0
write    4        0000a55a 0  0  0
status   1        1        a5 5a 0
read     0        00000100 0  0  0
read     4        0000a55a 0  0  0
write    8        12345678 2  0  0
read     8        00000000 2  0  0
read     4        0000a55a 0  0  0
write    0        00000000 0  0  0
status   1        0        a5 5a 0
download 6        2        0  0  0
status   0        0        a5 5a 0
write    0        00000001 0  0  0
status   1        0        a5 5a 0
write    0        00000000 0  0  0
status   0        0        a5 5a 0
button   1        0        0  0  0
status   1        0        a5 5a 0
button   0        0        0  0  0
status   0        0        a5 5a 0
coin     0        1        0  0  0
coin     2        4        0  0  0
coin     3        8        0  0  0
analog   00000000 40       c0 40 c0
analog   00000000 7f       00 7f 00
analog   00001200 40       81 df 3f
analog   00001200 01       fe 00 00
analog   00000440 10       80 e0 04
analog   00000440 7f       0c 03 1f
analog   00001640 55       f0 01 f5
analog   00001640 07       9c 0c 00
analog   00000800 7f       80 07 f8
analog   00000800 f1       33 ff 03
analog   00001a00 30       50 9f 5f
analog   00001a00 80       ff 00 01
analog   00000c40 20       40 60 30
analog   00000c40 60       f6 f1 90
analog   00001e40 40       10 eb af
analog   00001e40 70       ec 18 73

//--- sim/tb_arcade_ctrl.sv
`timescale 1ns/10ps

module tb_arcade_ctrl import arcade_ctrl_pkg::*; ();

	localparam int NUM_COINS = 4;
	localparam int MAX_CASES = 64;

	logic                 clk_sys = 1'b0;
	logic                 rst_n_i;
	axi_addr_t            s_awaddr_i;
	axi_addr_t            s_araddr_i;
	axi_data_t            s_wdata_i;
	axi_data_t            s_rdata_o;
	logic                 s_awvalid_i;
	logic                 s_wvalid_i;
	logic                 s_bready_i;
	logic                 s_arvalid_i;
	logic                 s_rready_i;
	logic                 s_awready_o;
	logic                 s_wready_o;
	logic                 s_bvalid_o;
	logic                 s_arready_o;
	logic                 s_rvalid_o;
	logic [1:0]           s_bresp_o;
	logic [1:0]           s_rresp_o;
	analog_t              analog_p1_i;
	analog_t              analog_p2_i;
	analog_t              analog_p1_o;
	analog_t              analog_p2_o;
	logic                 download_i;
	logic                 reset_button_i;
	logic                 vblank_i;
	logic                 sys_reset_o;
	logic                 pause_o;
	logic [NUM_COINS-1:0] coin_i;
	logic [NUM_COINS-1:0] coin_o;
	dip_t                 dswa_o;
	dip_t                 dswb_o;

	string     ops[MAX_CASES];
	axi_data_t cols[MAX_CASES][5];
	int        n_cases = 0;
	int        checks = 0;
	int        errors = 0;
	int        cycles = 0;
	int        limit = 40 * MAX_CASES + 200;
	integer    seed = 32'h225f;

	arcade_ctrl_top #(.NUM_COINS(NUM_COINS)) dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles, %0d errors so far",
				limit, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input logic [1:0] resp);
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		do @(negedge clk_sys); while (!s_awready_o);
		check_eq("wready with awready", s_wready_o, 1);
		@(negedge clk_sys);
		check_eq("awready after accept", s_awready_o, 0);
		check_eq("wready after accept", s_wready_o, 0);
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		// Random hold-off on the response channel
		repeat ({$random(seed)} % 4) @(negedge clk_sys);
		s_bready_i = 1'b1;
		while (!s_bvalid_o) @(negedge clk_sys);
		check_eq("bresp", s_bresp_o, resp);
		@(negedge clk_sys);
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, input axi_data_t data, input logic [1:0] resp);
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		do @(negedge clk_sys); while (!s_arready_o);
		@(negedge clk_sys);
		s_arvalid_i = 1'b0;
		repeat ({$random(seed)} % 4) @(negedge clk_sys);
		s_rready_i = 1'b1;
		while (!s_rvalid_o) @(negedge clk_sys);
		check_eq("rdata", s_rdata_o, data);
		check_eq("rresp", s_rresp_o, resp);
		@(negedge clk_sys);
		s_rready_i = 1'b0;
	endtask

	// One sample per cycle with each result two cycles behind its input
	task automatic analog_run(input int first, input int last);
		axi_write(REG_OPTIONS_ADDR, cols[first][0], RESP_OKAY);
		for (int t = first; t <= last + 1; t++) begin
			if (t <= last) begin
				analog_p1_i = cols[t][1][7:0];
				analog_p2_i = cols[t][2][7:0];
			end
			@(negedge clk_sys);
			if (t > first) begin
				check_eq("analog_p1_o", $unsigned(analog_p1_o), cols[t-1][3][7:0]);
				check_eq("analog_p2_o", $unsigned(analog_p2_o), cols[t-1][4][7:0]);
			end
		end
	endtask

	task automatic download_pulse(input int len, input int settle_exp);
		int n;
		download_i = 1'b1;
		repeat (len) @(negedge clk_sys);
		check_eq("sys_reset_o during download", sys_reset_o, 1);
		download_i = 1'b0;
		n = 0;
		while (sys_reset_o && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		check_eq("cycles until sys_reset_o low", n, settle_exp);
	endtask

	task automatic coin_press(input int idx, input logic [NUM_COINS-1:0] mask);
		coin_i[idx] = 1'b1;
		@(negedge clk_sys);
		coin_i = '0;
		repeat (3) @(negedge clk_sys);
		check_eq("coin_o before vblank", coin_o, 0);
		vblank_i = 1'b1;
		@(negedge clk_sys);
		check_eq("coin_o after first vblank", coin_o, mask);
		vblank_i = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_eq("coin_o within frame", coin_o, mask);
		vblank_i = 1'b1;
		@(negedge clk_sys);
		check_eq("coin_o after second vblank", coin_o, 0);
		vblank_i = 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		int    fd;
		string line;
		int    first;
		rst_n_i        = 1'b0;
		s_awaddr_i     = '0;
		s_araddr_i     = '0;
		s_wdata_i      = '0;
		s_awvalid_i    = 1'b0;
		s_wvalid_i     = 1'b0;
		s_bready_i     = 1'b0;
		s_arvalid_i    = 1'b0;
		s_rready_i     = 1'b0;
		analog_p1_i    = '0;
		analog_p2_i    = '0;
		download_i     = 1'b0;
		reset_button_i = 1'b0;
		vblank_i       = 1'b0;
		coin_i         = '0;

		fd = $fopen("sim/arcade_ctrl_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the cases file sim/arcade_ctrl_cases.txt");
		end else begin
			while (!$feof(fd) && n_cases < MAX_CASES) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					void'($sscanf(line, "%s %h %h %h %h %h", ops[n_cases],
						cols[n_cases][0], cols[n_cases][1], cols[n_cases][2],
						cols[n_cases][3], cols[n_cases][4]));
					n_cases++;
				end
			end
			$fclose(fd);
		end
		limit = 40 * n_cases + 200;

		repeat (8) @(negedge clk_sys);
		rst_n_i = 1'b1;
		@(negedge clk_sys);

		for (int i = 0; i < n_cases; i++) begin
			case (ops[i])
				"write":    axi_write(cols[i][0][3:0], cols[i][1], cols[i][2][1:0]);
				"read":     axi_read(cols[i][0][3:0], cols[i][1], cols[i][2][1:0]);
				"download": download_pulse(cols[i][0], cols[i][1]);
				"button":   reset_button_i = cols[i][0][0];
				"coin":     coin_press(cols[i][0], cols[i][1][NUM_COINS-1:0]);
				"status": begin
					repeat (2) @(negedge clk_sys);
					check_eq("sys_reset_o", sys_reset_o, cols[i][0]);
					check_eq("pause_o", pause_o, cols[i][1]);
					check_eq("dswa_o", dswa_o, cols[i][2]);
					check_eq("dswb_o", dswb_o, cols[i][3]);
				end
				"analog": begin
					first = i;
					while (i + 1 < n_cases && ops[i+1] == "analog"
							&& cols[i+1][0] == cols[first][0]) begin
						i++;
					end
					analog_run(first, i);
				end
				default: begin
					errors++;
					$display("Unknown operation %s on case %0d", ops[i], i);
				end
			endcase
		end

		$display("Cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- src/analog_scale.sv
`timescale 1ns/10ps

module analog_scale import arcade_ctrl_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n_i,
	opt_if.scale    opt,
	input  analog_t analog_p1_i,
	input  analog_t analog_p2_i,
	output analog_t analog_p1_o,
	output analog_t analog_p2_o
);

	// Sums are truncated back to 8 bits, so large values wrap
	function automatic analog_t scale(input analog_t d, input sens_t s, input logic inv);
		analog_t r;
		unique case (s)
			SENS_100: r = d;
			SENS_50:  r = d >>> 1;
			SENS_25:  r = d >>> 2;
			SENS_12:  r = d >>> 3;
			SENS_6:   r = d >>> 4;
			SENS_200: r = d + d;
			SENS_150: r = d + (d >>> 1);
			SENS_125: r = d + (d >>> 2);
		endcase
		if (inv && r != 0) begin
			r = ~r;
		end
		return r;
	endfunction

	analog_t p1_s1;
	analog_t p2_s1;
	analog_t p1_s2;
	analog_t p2_s2;

	// Stage 1 swaps the players
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			p1_s1 <= '0;
			p2_s1 <= '0;
		end else if (opt.joyswap) begin
			p1_s1 <= analog_p2_i;
			p2_s1 <= analog_p1_i;
		end else begin
			p1_s1 <= analog_p1_i;
			p2_s1 <= analog_p2_i;
		end
	end

	// Stage 2 applies sensitivity and invert
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			p1_s2 <= '0;
			p2_s2 <= '0;
		end else begin
			p1_s2 <= scale(p1_s1, opt.sens, opt.invert);
			p2_s2 <= scale(p2_s1, opt.sens, opt.invert);
		end
	end

	assign analog_p1_o = p1_s2;
	assign analog_p2_o = p2_s2;

endmodule

//--- src/arcade_ctrl_pkg.sv
package arcade_ctrl_pkg;

	// AXI4-Lite bus
	typedef logic [3:0]  axi_addr_t;
	typedef logic [31:0] axi_data_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map
	localparam axi_addr_t REG_OPTIONS_ADDR = 4'h0;
	localparam axi_addr_t REG_DIP_ADDR     = 4'h4;

	// Option word fields
	localparam int OPT_RESET_BIT   = 0;
	localparam int OPT_JOYSWAP_BIT = 6;
	localparam int OPT_PAUSE_BIT   = 8;
	localparam int OPT_SENS_LSB    = 9;
	localparam int OPT_SENS_WIDTH  = 3;
	localparam int OPT_INVERT_BIT  = 12;

	// DIP word bytes
	localparam int DIPA_LSB = 0;
	localparam int DIPB_LSB = 8;

	typedef logic signed [7:0] analog_t;
	typedef logic [7:0]        dip_t;

	// Rotary sensitivity as percent of the raw value
	typedef enum logic [OPT_SENS_WIDTH-1:0] {
		SENS_100 = 3'd0,
		SENS_50  = 3'd1,
		SENS_25  = 3'd2,
		SENS_12  = 3'd3,
		SENS_6   = 3'd4,
		SENS_200 = 3'd5,
		SENS_150 = 3'd6,
		SENS_125 = 3'd7
	} sens_t;

endpackage

//--- src/arcade_ctrl_top.sv
`timescale 1ns/10ps

module arcade_ctrl_top import arcade_ctrl_pkg::*; #(
	parameter int NUM_COINS = 4
) (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,

	input  axi_addr_t            s_awaddr_i,
	input  logic                 s_awvalid_i,
	output logic                 s_awready_o,
	input  axi_data_t            s_wdata_i,
	input  logic                 s_wvalid_i,
	output logic                 s_wready_o,
	output logic                 s_bvalid_o,
	output logic [1:0]           s_bresp_o,
	input  logic                 s_bready_i,
	input  axi_addr_t            s_araddr_i,
	input  logic                 s_arvalid_i,
	output logic                 s_arready_o,
	output logic                 s_rvalid_o,
	output axi_data_t            s_rdata_o,
	output logic [1:0]           s_rresp_o,
	input  logic                 s_rready_i,

	input  analog_t              analog_p1_i,
	input  analog_t              analog_p2_i,
	output analog_t              analog_p1_o,
	output analog_t              analog_p2_o,

	input  logic                 download_i,
	input  logic                 reset_button_i,
	input  logic                 vblank_i,
	input  logic [NUM_COINS-1:0] coin_i,
	output logic [NUM_COINS-1:0] coin_o,
	output logic                 sys_reset_o,
	output logic                 pause_o,
	output dip_t                 dswa_o,
	output dip_t                 dswb_o
);

	opt_if opt_bus ();

	opt_regs_decode u_decode (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bresp_o   (s_bresp_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rready_i  (s_rready_i),
		.opt         (opt_bus.source)
	);

	analog_scale u_execute (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.opt         (opt_bus.scale),
		.analog_p1_i (analog_p1_i),
		.analog_p2_i (analog_p2_i),
		.analog_p1_o (analog_p1_o),
		.analog_p2_o (analog_p2_o)
	);

	ctrl_result #(
		.NUM_COINS (NUM_COINS)
	) u_result (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.opt            (opt_bus.ctrl),
		.download_i     (download_i),
		.reset_button_i (reset_button_i),
		.vblank_i       (vblank_i),
		.coin_i         (coin_i),
		.coin_o         (coin_o),
		.sys_reset_o    (sys_reset_o),
		.pause_o        (pause_o),
		.dswa_o         (dswa_o),
		.dswb_o         (dswb_o)
	);

endmodule

//--- src/ctrl_result.sv
`timescale 1ns/10ps

module ctrl_result import arcade_ctrl_pkg::*; #(
	parameter int NUM_COINS = 4
) (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	opt_if.ctrl                  opt,
	input  logic                 download_i,
	input  logic                 reset_button_i,
	input  logic                 vblank_i,
	input  logic [NUM_COINS-1:0] coin_i,
	output logic [NUM_COINS-1:0] coin_o,
	output logic                 sys_reset_o,
	output logic                 pause_o,
	output dip_t                 dswa_o,
	output dip_t                 dswb_o
);

	logic                 download_q;
	logic                 rom_loaded;
	logic                 sys_reset_q;
	logic                 vblank_q;
	logic                 vblank_rise;
	logic [NUM_COINS-1:0] coin_q;
	logic [NUM_COINS-1:0] press;
	logic [NUM_COINS-1:0] pending;
	logic [NUM_COINS-1:0] latch_q;
	logic [NUM_COINS-1:0] pulse_q;

	// System reset held until the first download has finished
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			download_q  <= 1'b0;
			rom_loaded  <= 1'b0;
			sys_reset_q <= 1'b1;
		end else begin
			download_q  <= download_i;
			sys_reset_q <= download_i | opt.reset_req | reset_button_i | ~rom_loaded;
			if (download_q && !download_i) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	assign vblank_rise = vblank_i & ~vblank_q;
	assign press       = coin_i & ~coin_q;
	assign pending     = latch_q | press;

	// A press waiting behind an active pulse stays latched for the next frame
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vblank_q <= 1'b0;
			coin_q   <= '0;
			latch_q  <= '0;
			pulse_q  <= '0;
		end else begin
			vblank_q <= vblank_i;
			coin_q   <= coin_i;
			if (vblank_rise) begin
				pulse_q <= ~pulse_q & pending;
				latch_q <= pulse_q & pending;
			end else begin
				latch_q <= pending;
			end
		end
	end

	assign coin_o      = pulse_q;
	assign sys_reset_o = sys_reset_q;
	assign pause_o     = opt.pause;
	assign dswa_o      = opt.dswa;
	assign dswb_o      = opt.dswb;

	a_rom_loaded_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rom_loaded |=> rom_loaded);

endmodule

//--- src/opt_if.sv
`timescale 1ns/10ps

interface opt_if import arcade_ctrl_pkg::*; ();

	logic  joyswap;
	logic  pause;
	sens_t sens;
	logic  invert;
	logic  reset_req;
	dip_t  dswa;
	dip_t  dswb;

	modport source (
		output joyswap,
		output pause,
		output sens,
		output invert,
		output reset_req,
		output dswa,
		output dswb
	);

	// Analog path only needs the control fields
	modport scale (
		input joyswap,
		input sens,
		input invert
	);

	modport ctrl (
		input pause,
		input reset_req,
		input dswa,
		input dswb
	);

endinterface

//--- src/opt_regs_decode.sv
`timescale 1ns/10ps

module opt_regs_decode import arcade_ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n_i,

	input  axi_addr_t  s_awaddr_i,
	input  logic       s_awvalid_i,
	output logic       s_awready_o,
	input  axi_data_t  s_wdata_i,
	input  logic       s_wvalid_i,
	output logic       s_wready_o,
	output logic       s_bvalid_o,
	output logic [1:0] s_bresp_o,
	input  logic       s_bready_i,

	input  axi_addr_t  s_araddr_i,
	input  logic       s_arvalid_i,
	output logic       s_arready_o,
	output logic       s_rvalid_o,
	output axi_data_t  s_rdata_o,
	output logic [1:0] s_rresp_o,
	input  logic       s_rready_i,

	opt_if.source      opt
);

	function automatic logic addr_hit(input axi_addr_t addr);
		return (addr == REG_OPTIONS_ADDR) || (addr == REG_DIP_ADDR);
	endfunction

	logic       aw_ready_q;
	logic       b_valid_q;
	logic [1:0] b_resp_q;
	logic       ar_ready_q;
	logic       r_valid_q;
	logic [1:0] r_resp_q;
	axi_data_t  r_data_q;
	axi_data_t  rd_word;
	axi_data_t  opt_q;
	axi_data_t  dip_q;
	logic       wr_fire;
	logic       rd_fire;

	assign wr_fire = aw_ready_q && s_awvalid_i && s_wvalid_i;
	assign rd_fire = ar_ready_q && s_arvalid_i;

	// Unmapped addresses read as zero
	always_comb begin
		case (s_araddr_i)
			REG_OPTIONS_ADDR: rd_word = opt_q;
			REG_DIP_ADDR:     rd_word = dip_q;
			default:          rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			aw_ready_q <= 1'b0;
			b_valid_q  <= 1'b0;
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
			opt_q      <= '0;
			dip_q      <= '0;
		end else begin
			// Write accepted only with both channels valid and no response pending
			if (aw_ready_q) begin
				aw_ready_q <= 1'b0;
			end else if (!b_valid_q && s_awvalid_i && s_wvalid_i) begin
				aw_ready_q <= 1'b1;
			end
			if (wr_fire) begin
				b_valid_q <= 1'b1;
			end else if (s_bready_i) begin
				b_valid_q <= 1'b0;
			end
			if (wr_fire && s_awaddr_i == REG_OPTIONS_ADDR) begin
				opt_q <= s_wdata_i;
			end
			if (wr_fire && s_awaddr_i == REG_DIP_ADDR) begin
				dip_q <= s_wdata_i;
			end

			// Read side
			if (ar_ready_q) begin
				ar_ready_q <= 1'b0;
			end else if (!r_valid_q && s_arvalid_i) begin
				ar_ready_q <= 1'b1;
			end
			if (rd_fire) begin
				r_valid_q <= 1'b1;
			end else if (s_rready_i) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_fire) begin
			b_resp_q <= addr_hit(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_fire) begin
			r_resp_q <= addr_hit(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
			r_data_q <= rd_word;
		end
	end

	assign s_awready_o = aw_ready_q;
	assign s_wready_o  = aw_ready_q;
	assign s_bvalid_o  = b_valid_q;
	assign s_bresp_o   = b_resp_q;
	assign s_arready_o = ar_ready_q;
	assign s_rvalid_o  = r_valid_q;
	assign s_rdata_o   = r_data_q;
	assign s_rresp_o   = r_resp_q;

	// DIP switches are active low
	assign opt.reset_req = opt_q[OPT_RESET_BIT];
	assign opt.joyswap   = opt_q[OPT_JOYSWAP_BIT];
	assign opt.pause     = opt_q[OPT_PAUSE_BIT];
	assign opt.sens      = sens_t'(opt_q[OPT_SENS_LSB +: OPT_SENS_WIDTH]);
	assign opt.invert    = opt_q[OPT_INVERT_BIT];
	assign opt.dswa      = ~dip_q[DIPA_LSB +: $bits(dip_t)];
	assign opt.dswb      = ~dip_q[DIPB_LSB +: $bits(dip_t)];

	a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

	a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule
